//--- toom3_params.svh
`ifndef TOOM3_PARAMS_SVH
`define TOOM3_PARAMS_SVH

// ====================
// datapath widths
// ====================
`define TOOM_LIMB_W 16
`define TOOM_OP_W 48
`define TOOM_EVAL_W 18    // limb plus room for the x^2 shift
`define TOOM_SUB_W 35
`define TOOM_WORK_W 36
`define TOOM_PROD_W 95

`define TOOM_APB_AW 8
`define TOOM_APB_DW 32

// ====================
// register map
// ====================
`define TOOM_REG_A_LO 8'h00
`define TOOM_REG_A_HI 8'h04
`define TOOM_REG_B_LO 8'h08
`define TOOM_REG_B_HI 8'h0C
`define TOOM_REG_CTRL 8'h10
`define TOOM_REG_STATUS 8'h14
`define TOOM_REG_P0 8'h18
`define TOOM_REG_P1 8'h1C
`define TOOM_REG_P2 8'h20

`endif

//--- toom3_pkg.sv
`default_nettype none
`include "toom3_params.svh"

package toom3_pkg;

    typedef enum logic [3:0] {
        seq_idle,
        seq_eval,
        seq_mul_1,       // points 0 and 1
        seq_mul_2,       // points x and x+1
        seq_mul_last,    // point at infinity
        seq_interp,
        seq_div,
        seq_recomb,
        seq_finish
    } seq_state_t;

    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`TOOM_APB_AW-1:0] paddr;
        logic [`TOOM_APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`TOOM_APB_DW-1:0] prdata;
        logic                    pready;
        logic                    pslverr;
    } apb_rsp_t;

    // one pair of evaluated operands for a sub-multiplier
    typedef struct packed {
        logic [`TOOM_EVAL_W-1:0] op_a;
        logic [`TOOM_EVAL_W-1:0] op_b;
    } mul_job_t;

endpackage

`default_nettype wire

//--- apb_regs.sv
`timescale 1ns/10ps
`include "toom3_params.svh"
`default_nettype none

module apb_regs import toom3_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  apb_req_t                apb_req,
    output apb_rsp_t                apb_rsp,
    output logic [`TOOM_OP_W-1:0]   a,
    output logic [`TOOM_OP_W-1:0]   b,
    output logic                    start,
    input  logic                    busy,
    input  logic [`TOOM_PROD_W-1:0] product
);

    logic [`TOOM_APB_DW-1:0]             a_lo;
    logic [`TOOM_APB_DW-1:0]             b_lo;
    logic [`TOOM_OP_W-`TOOM_APB_DW-1:0] a_hi;
    logic [`TOOM_OP_W-`TOOM_APB_DW-1:0] b_hi;
    logic                                done;
    logic                                busy_q;

    logic                    access;
    logic                    mapped;
    logic                    running;
    logic                    start_req;
    logic                    refuse;
    logic                    wr_en;
    logic [`TOOM_APB_DW-1:0] rd_data;

    assign a = {a_hi, a_lo};
    assign b = {b_hi, b_lo};

    assign access  = apb_req.psel & apb_req.penable;
    assign running = busy | start;    // start pulse counts before busy rises

    assign start_req = access & apb_req.pwrite & apb_req.pwdata[0]
                     & (apb_req.paddr == `TOOM_REG_CTRL);
    assign refuse    = start_req & running;
    assign wr_en     = access & apb_req.pwrite & mapped & !refuse;

    // ====================
    // address decode and read mux
    // ====================
    always_comb begin
        mapped  = 1'b1;
        rd_data = '0;
        case (apb_req.paddr)
            `TOOM_REG_A_LO:   rd_data = a_lo;
            `TOOM_REG_A_HI:   rd_data = `TOOM_APB_DW'(a_hi);
            `TOOM_REG_B_LO:   rd_data = b_lo;
            `TOOM_REG_B_HI:   rd_data = `TOOM_APB_DW'(b_hi);
            `TOOM_REG_CTRL:   rd_data = '0;    // start is self clearing
            `TOOM_REG_STATUS: rd_data = `TOOM_APB_DW'({done, running});
            `TOOM_REG_P0:     rd_data = product[31:0];
            `TOOM_REG_P1:     rd_data = product[63:32];
            `TOOM_REG_P2:     rd_data = `TOOM_APB_DW'(product[`TOOM_PROD_W-1:64]);
            default:          mapped = 1'b0;
        endcase
    end

    always_comb begin
        apb_rsp.prdata  = rd_data;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access & (!mapped | refuse);
    end

    // ====================
    // register writes
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            a_lo   <= '0;
            a_hi   <= '0;
            b_lo   <= '0;
            b_hi   <= '0;
            start  <= 1'b0;
            done   <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            start  <= 1'b0;
            busy_q <= busy;

            if (busy_q && !busy) begin
                done <= 1'b1;    // sticky until next start
            end

            // operands stay frozen while a job runs
            if (wr_en && !running) begin
                case (apb_req.paddr)
                    `TOOM_REG_A_LO: a_lo <= apb_req.pwdata;
                    `TOOM_REG_A_HI: a_hi <= apb_req.pwdata[`TOOM_OP_W-`TOOM_APB_DW-1:0];
                    `TOOM_REG_B_LO: b_lo <= apb_req.pwdata;
                    `TOOM_REG_B_HI: b_hi <= apb_req.pwdata[`TOOM_OP_W-`TOOM_APB_DW-1:0];
                    default: ;
                endcase
            end

            if (wr_en && start_req) begin
                start <= 1'b1;
                done  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- toom3_sequencer.sv
`timescale 1ns/10ps
`include "toom3_params.svh"
`default_nettype none

module toom3_sequencer import toom3_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic [`TOOM_OP_W-1:0]   a,
    input  logic [`TOOM_OP_W-1:0]   b,
    output logic                    busy,
    output logic [`TOOM_PROD_W-1:0] product,
    output logic                    mul_go_1,
    output logic                    mul_go_2,
    output mul_job_t                job_1,
    output mul_job_t                job_2,
    input  logic [`TOOM_SUB_W-1:0]  sub_1,
    input  logic [`TOOM_SUB_W-1:0]  sub_2,
    input  logic                    mul_valid_1,
    input  logic                    mul_valid_2,
    output logic                    div_go,
    output logic [`TOOM_WORK_W-1:0] dividend,
    input  logic [`TOOM_WORK_W-1:0] quotient,
    input  logic                    div_valid
);

    seq_state_t state;
    logic       issued;    // units of the current step launched
    logic       got_1;
    logic       got_2;
    logic       div_pass;  // 0 for c3, 1 for c2
    logic       round_done;

    mul_job_t                ev [5];
    logic [`TOOM_WORK_W-1:0] w0, w1, w2, w3, w4;
    logic [`TOOM_WORK_W-1:0] div_stage_2;
    logic [`TOOM_PROD_W-1:0] recomb;

    // operand at 0, 1, x, x+1 and infinity
    function automatic logic [`TOOM_EVAL_W-1:0] eval_at(
        input logic [`TOOM_OP_W-1:0] op,
        input logic [2:0]            pt
    );
        logic [`TOOM_EVAL_W-1:0] l0, l1, l2;
        l0 = `TOOM_EVAL_W'(op[`TOOM_LIMB_W-1:0]);
        l1 = `TOOM_EVAL_W'(op[2*`TOOM_LIMB_W-1:`TOOM_LIMB_W]);
        l2 = `TOOM_EVAL_W'(op[3*`TOOM_LIMB_W-1:2*`TOOM_LIMB_W]);
        case (pt)
            3'd0:    eval_at = l0;
            3'd1:    eval_at = l0 ^ l1 ^ l2;
            3'd2:    eval_at = l0 ^ (l1 << 1) ^ (l2 << 2);
            3'd3:    eval_at = l0 ^ l1 ^ l2 ^ (l1 << 1) ^ (l2 << 2);
            default: eval_at = l2;
        endcase
    endfunction

    assign busy       = (state != seq_idle);
    assign round_done = (got_1 | mul_valid_1) & (got_2 | mul_valid_2);

    // w1 = c1+c2+c3, w2 = T2, w3 = c3 once the first division is back
    assign div_stage_2 = w2 ^ w1 ^ (w4 << 3) ^ (w3 << 2) ^ w3;    // c2 (x+1)

    assign recomb = `TOOM_PROD_W'(w0)
                  ^ (`TOOM_PROD_W'(w1) << `TOOM_LIMB_W)
                  ^ (`TOOM_PROD_W'(w2) << 2*`TOOM_LIMB_W)
                  ^ (`TOOM_PROD_W'(w3) << 3*`TOOM_LIMB_W)
                  ^ (`TOOM_PROD_W'(w4) << 4*`TOOM_LIMB_W);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= seq_idle;
            issued   <= 1'b0;
            got_1    <= 1'b0;
            got_2    <= 1'b0;
            div_pass <= 1'b0;
            mul_go_1 <= 1'b0;
            mul_go_2 <= 1'b0;
            div_go   <= 1'b0;
            product  <= '0;
        end else begin
            mul_go_1 <= 1'b0;
            mul_go_2 <= 1'b0;
            div_go   <= 1'b0;
            if (mul_valid_1) got_1 <= 1'b1;
            if (mul_valid_2) got_2 <= 1'b1;

            case (state)
                seq_idle: begin
                    if (start) state <= seq_eval;
                end
                seq_eval: begin
                    for (int i = 0; i < 5; i++) begin
                        ev[i].op_a <= eval_at(a, 3'(i));
                        ev[i].op_b <= eval_at(b, 3'(i));
                    end
                    issued <= 1'b0;
                    state  <= seq_mul_1;
                end
                seq_mul_1, seq_mul_2: begin
                    if (!issued) begin
                        job_1    <= (state == seq_mul_1) ? ev[0] : ev[2];
                        job_2    <= (state == seq_mul_1) ? ev[1] : ev[3];
                        mul_go_1 <= 1'b1;
                        mul_go_2 <= 1'b1;
                        got_1    <= 1'b0;
                        got_2    <= 1'b0;
                        issued   <= 1'b1;
                    end else begin
                        if (mul_valid_1 && state == seq_mul_1) w0 <= `TOOM_WORK_W'(sub_1);
                        if (mul_valid_2 && state == seq_mul_1) w1 <= `TOOM_WORK_W'(sub_2);
                        if (mul_valid_1 && state == seq_mul_2) w2 <= `TOOM_WORK_W'(sub_1);
                        if (mul_valid_2 && state == seq_mul_2) w3 <= `TOOM_WORK_W'(sub_2);
                        if (round_done) begin
                            issued <= 1'b0;
                            state  <= (state == seq_mul_1) ? seq_mul_2 : seq_mul_last;
                        end
                    end
                end
                seq_mul_last: begin
                    if (!issued) begin
                        job_1    <= ev[4];
                        mul_go_1 <= 1'b1;
                        got_1    <= 1'b0;
                        got_2    <= 1'b1;    // second unit sits this round out
                        issued   <= 1'b1;
                    end else if (round_done) begin
                        w4     <= `TOOM_WORK_W'(sub_1);
                        issued <= 1'b0;
                        state  <= seq_interp;
                    end
                end
                seq_interp: begin
                    w1    <= w1 ^ w0 ^ w4;              // c1+c2+c3
                    w2    <= (w2 ^ w0) >> 1;            // T2, exact shift by x
                    w3    <= (w3 ^ w2 ^ w1 ^ w0) >> 1;  // c3 (x+1)
                    state <= seq_div;
                end
                seq_div: begin
                    if (!issued) begin
                        dividend <= div_pass ? div_stage_2 : w3;
                        div_go   <= 1'b1;
                        issued   <= 1'b1;
                    end else if (div_valid) begin
                        issued <= 1'b0;
                        if (!div_pass) begin
                            w3       <= quotient;
                            div_pass <= 1'b1;
                        end else begin
                            w2       <= quotient;
                            div_pass <= 1'b0;
                            state    <= seq_recomb;
                        end
                    end
                end
                seq_recomb: begin
                    w1    <= w1 ^ w2 ^ w3;    // c1
                    state <= seq_finish;
                end
                seq_finish: begin
                    product <= recomb;        // overlapped limbs at 16 bit steps
                    state   <= seq_idle;
                end
                default: state <= seq_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- clmul_seq.sv
`timescale 1ns/10ps
`include "toom3_params.svh"
`default_nettype none

module clmul_seq import toom3_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   go,
    input  mul_job_t               job,
    output logic [`TOOM_SUB_W-1:0] sub_product,
    output logic                   valid
);

    logic [`TOOM_EVAL_W-1:0] mcand;
    logic [`TOOM_EVAL_W-1:0] mplier;
    logic [`TOOM_SUB_W-1:0]  acc;
    logic [4:0]              bit_cnt;
    logic                    running;

    assign sub_product = acc;

    // ====================
    // bit counter
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            valid   <= 1'b0;
            bit_cnt <= '0;
        end else begin
            valid <= 1'b0;
            if (go) begin
                running <= 1'b1;
                bit_cnt <= 5'(`TOOM_EVAL_W - 1);    // top bit handled on load
            end else if (running) begin
                bit_cnt <= bit_cnt - 5'd1;
                if (bit_cnt == 5'd1) begin
                    running <= 1'b0;
                    valid   <= 1'b1;
                end
            end
        end
    end

    // shift and xor, multiplier msb first
    always_ff @(posedge clk) begin
        if (go) begin
            mcand  <= job.op_a;
            mplier <= job.op_b << 1;
            acc    <= job.op_b[`TOOM_EVAL_W-1] ? `TOOM_SUB_W'(job.op_a) : '0;
        end else if (running) begin
            acc    <= (acc << 1) ^ (mplier[`TOOM_EVAL_W-1] ? `TOOM_SUB_W'(mcand) : '0);
            mplier <= mplier << 1;
        end
    end

endmodule

`default_nettype wire

//--- exact_div.sv
`timescale 1ns/10ps
`include "toom3_params.svh"
`default_nettype none

module exact_div (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    go,
    input  logic [`TOOM_WORK_W-1:0] dividend,
    output logic [`TOOM_WORK_W-1:0] quotient,
    output logic                    valid
);

    logic [`TOOM_WORK_W-1:0] rem;
    logic [5:0]              bit_cnt;
    logic                    running;
    logic                    q_next;

    // q(i) = d(i+1) ^ q(i+1), working down from the top
    assign q_next = rem[`TOOM_WORK_W-1] ^ quotient[0];

    // ====================
    // bit counter
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            valid   <= 1'b0;
            bit_cnt <= '0;
        end else begin
            valid <= 1'b0;
            if (go) begin
                running <= 1'b1;
                bit_cnt <= 6'(`TOOM_WORK_W - 1);
            end else if (running) begin
                bit_cnt <= bit_cnt - 6'd1;
                if (bit_cnt == 6'd1) begin
                    running <= 1'b0;
                    valid   <= 1'b1;
                end
            end
        end
    end

    // quotient shifts in one bit per cycle, top bit first
    always_ff @(posedge clk) begin
        if (go) begin
            rem      <= dividend;
            quotient <= '0;    // top quotient bit is always zero
        end else if (running) begin
            quotient <= {quotient[`TOOM_WORK_W-2:0], q_next};
            rem      <= rem << 1;
        end
    end

endmodule

`default_nettype wire

//--- toom3_top.sv
`timescale 1ns/10ps
`include "toom3_params.svh"
`default_nettype none

module toom3_top import toom3_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic [`TOOM_OP_W-1:0]   a;
    logic [`TOOM_OP_W-1:0]   b;
    logic                    start;
    logic                    busy;
    logic [`TOOM_PROD_W-1:0] product;

    logic                   mul_go_1;
    logic                   mul_go_2;
    mul_job_t               job_1;
    mul_job_t               job_2;
    logic [`TOOM_SUB_W-1:0] sub_1;
    logic [`TOOM_SUB_W-1:0] sub_2;
    logic                   mul_valid_1;
    logic                   mul_valid_2;

    logic                    div_go;
    logic                    div_valid;
    logic [`TOOM_WORK_W-1:0] dividend;
    logic [`TOOM_WORK_W-1:0] quotient;

    apb_regs apb_regs_inst (
        .clk(clk), .reset(reset),
        .apb_req(apb_req), .apb_rsp(apb_rsp),
        .a(a), .b(b), .start(start), .busy(busy), .product(product)
    );

    toom3_sequencer toom3_sequencer_inst (
        .clk(clk), .reset(reset),
        .start(start), .a(a), .b(b), .busy(busy), .product(product),
        .mul_go_1(mul_go_1), .mul_go_2(mul_go_2), .job_1(job_1), .job_2(job_2),
        .sub_1(sub_1), .sub_2(sub_2), .mul_valid_1(mul_valid_1), .mul_valid_2(mul_valid_2),
        .div_go(div_go), .dividend(dividend), .quotient(quotient), .div_valid(div_valid)
    );

    clmul_seq clmul_seq_1_inst (
        .clk(clk), .reset(reset),
        .go(mul_go_1), .job(job_1), .sub_product(sub_1), .valid(mul_valid_1)
    );

    clmul_seq clmul_seq_2_inst (
        .clk(clk), .reset(reset),
        .go(mul_go_2), .job(job_2), .sub_product(sub_2), .valid(mul_valid_2)
    );

    exact_div exact_div_inst (
        .clk(clk), .reset(reset),
        .go(div_go), .dividend(dividend), .quotient(quotient), .valid(div_valid)
    );

endmodule

`default_nettype wire

//--- tb_toom3.sv
`timescale 1ns/10ps
`include "toom3_params.svh"
`default_nettype none

module tb_toom3 import toom3_pkg::*; ();

    logic     clk;
    logic     reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    int          error_count;
    int          timeout_count;
    logic [31:0] lfsr;

    toom3_top toom3_top_inst (
        .clk(clk),
        .reset(reset),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ====================
    // reference model and stimulus source
    // ====================
    function automatic logic [`TOOM_PROD_W-1:0] gf2_mul(
        input logic [`TOOM_OP_W-1:0] x,
        input logic [`TOOM_OP_W-1:0] y
    );
        logic [`TOOM_PROD_W-1:0] acc;
        acc = '0;
        for (int i = 0; i < `TOOM_OP_W; i++) begin
            if (y[i]) acc ^= `TOOM_PROD_W'(x) << i;    // xor instead of add
        end
        return acc;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;    // taps 32 22 2 1
        end else begin
            return s >> 1;
        end
    endfunction

    task automatic draw_operand(output logic [`TOOM_OP_W-1:0] v);
        v = '0;
        for (int i = 0; i < `TOOM_OP_W; i++) begin
            v    = {v[`TOOM_OP_W-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
            error_count++;
        end
    endtask

    // ====================
    // apb transfers
    // ====================
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b1;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);    // middle of the access cycle
        check_word($sformatf("apb_rsp.pslverr (write %0h)", addr),
                   32'(exp_err), 32'(apb_rsp.pslverr));
        check_word($sformatf("apb_rsp.pready (write %0h)", addr),
                   32'h1, 32'(apb_rsp.pready));
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, input logic exp_err);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b0;
        apb_req.paddr   <= addr;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata;
        check_word($sformatf("apb_rsp.pslverr (read %0h)", addr),
                   32'(exp_err), 32'(apb_rsp.pslverr));
        check_word($sformatf("apb_rsp.pready (read %0h)", addr),
                   32'h1, 32'(apb_rsp.pready));
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic load_and_start(input logic [`TOOM_OP_W-1:0] x, input logic [`TOOM_OP_W-1:0] y);
        apb_write(`TOOM_REG_A_LO, x[31:0], 1'b0);
        apb_write(`TOOM_REG_A_HI, 32'(x[`TOOM_OP_W-1:32]), 1'b0);
        apb_write(`TOOM_REG_B_LO, y[31:0], 1'b0);
        apb_write(`TOOM_REG_B_HI, 32'(y[`TOOM_OP_W-1:32]), 1'b0);
        apb_write(`TOOM_REG_CTRL, 32'h1, 1'b0);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int          waited;
        status = '0;
        waited = 0;
        while (!status[1] && waited < 2000) begin
            apb_read(`TOOM_REG_STATUS, status, 1'b0);
            waited += 3;    // one read spans three clocks
        end
        if (!status[1]) begin
            $display("timeout: done bit not set within 2000 cycles");
            timeout_count++;
        end else begin
            check_word("STATUS busy when done", 32'h0, 32'(status[0]));
        end
    endtask

    task automatic check_product(input logic [`TOOM_OP_W-1:0] x, input logic [`TOOM_OP_W-1:0] y,
                                 input string label);
        logic [`TOOM_PROD_W-1:0] expected;
        logic [31:0]             word;
        expected = gf2_mul(x, y);
        apb_read(`TOOM_REG_P0, word, 1'b0);
        check_word($sformatf("P0 (%s)", label), expected[31:0], word);
        apb_read(`TOOM_REG_P1, word, 1'b0);
        check_word($sformatf("P1 (%s)", label), expected[63:32], word);
        apb_read(`TOOM_REG_P2, word, 1'b0);
        check_word($sformatf("P2 (%s)", label), 32'(expected[`TOOM_PROD_W-1:64]), word);
    endtask

    task automatic run_product(input logic [`TOOM_OP_W-1:0] x, input logic [`TOOM_OP_W-1:0] y,
                               input string label);
        load_and_start(x, y);
        wait_done();
        check_product(x, y, label);
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic check_reset_state();
        logic [31:0] word;
        apb_read(`TOOM_REG_STATUS, word, 1'b0);
        check_word("STATUS after reset", 32'h0, word);
        apb_read(`TOOM_REG_A_LO, word, 1'b0);
        check_word("A_LO after reset", 32'h0, word);
        apb_read(`TOOM_REG_P0, word, 1'b0);
        check_word("P0 after reset", 32'h0, word);
        apb_read(`TOOM_REG_P1, word, 1'b0);
        check_word("P1 after reset", 32'h0, word);
        apb_read(`TOOM_REG_P2, word, 1'b0);
        check_word("P2 after reset", 32'h0, word);
    endtask

    task automatic check_register_readback();
        logic [31:0] word;
        apb_write(`TOOM_REG_A_LO, 32'h1234_5678, 1'b0);
        apb_write(`TOOM_REG_A_HI, 32'hFFFF_A5C3, 1'b0);
        apb_write(`TOOM_REG_B_LO, 32'h9ABC_DEF0, 1'b0);
        apb_write(`TOOM_REG_B_HI, 32'h1357_2468, 1'b0);
        apb_read(`TOOM_REG_A_LO, word, 1'b0);
        check_word("A_LO", 32'h1234_5678, word);
        apb_read(`TOOM_REG_A_HI, word, 1'b0);
        check_word("A_HI", 32'h0000_A5C3, word);    // only 16 bits kept
        apb_read(`TOOM_REG_B_LO, word, 1'b0);
        check_word("B_LO", 32'h9ABC_DEF0, word);
        apb_read(`TOOM_REG_B_HI, word, 1'b0);
        check_word("B_HI", 32'h0000_2468, word);
    endtask

    task automatic check_directed_products();
        run_product(48'h0, 48'h8765_4321_ABCD, "zero times value");
        run_product(48'h5A5A_C3C3_0F0F, 48'h0, "value times zero");
        run_product(48'h1, 48'hFEDC_BA98_7654, "one times value");
        run_product(48'h8000_0000_0000, 48'h8000_0000_0000, "x47 squared");
        run_product(48'hFFFF_FFFF_FFFF, 48'hFFFF_FFFF_FFFF, "all ones");
        run_product(48'h0000_0000_BEEF, 48'h0000_CAFE_0000, "limb 0 times limb 1");
        run_product(48'hF00D_0000_0000, 48'h0000_0000_1234, "limb 2 times limb 0");
        run_product(48'h9001_0000_0000, 48'hFFFF_0000_0000, "limb 2 times limb 2");
    endtask

    task automatic check_random_products();
        logic [`TOOM_OP_W-1:0] x;
        logic [`TOOM_OP_W-1:0] y;
        for (int n = 0; n < 20; n++) begin
            draw_operand(x);
            draw_operand(y);
            run_product(x, y, $sformatf("random pair %0d", n));
        end
    endtask

    task automatic check_busy_and_refusal();
        logic [31:0] status;
        load_and_start(48'h3C3C_1234_ABCD, 48'hC001_D00D_7777);
        apb_read(`TOOM_REG_STATUS, status, 1'b0);
        check_word("STATUS busy after start", 32'h1, 32'(status[0]));
        apb_write(`TOOM_REG_CTRL, 32'h1, 1'b1);    // refused while running
        wait_done();
        check_product(48'h3C3C_1234_ABCD, 48'hC001_D00D_7777, "start while busy");
    endtask

    task automatic check_unmapped_access();
        logic [31:0] word;
        apb_write(8'h24, 32'hDEAD_BEEF, 1'b1);
        apb_read(8'h24, word, 1'b1);
        check_word("prdata at 24", 32'h0, word);
        apb_read(8'hFC, word, 1'b1);
        check_word("prdata at fc", 32'h0, word);
        apb_read(8'h02, word, 1'b1);
        check_word("prdata at 02", 32'h0, word);
    endtask

    task automatic check_back_to_back();
        logic [31:0] status;
        run_product(48'h0123_4567_89AB, 48'hFEDC_0000_3210, "first of pair");
        apb_read(`TOOM_REG_STATUS, status, 1'b0);
        check_word("STATUS done after first", 32'h1, 32'(status[1]));
        load_and_start(48'hA5A5_5A5A_FFFF, 48'h8001_0001_0001);
        apb_read(`TOOM_REG_STATUS, status, 1'b0);
        check_word("STATUS done after second start", 32'h0, 32'(status[1]));
        wait_done();
        check_product(48'hA5A5_5A5A_FFFF, 48'h8001_0001_0001, "second of pair");
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        error_count   = 0;
        timeout_count = 0;
        lfsr          = 32'h8cd4_0751;
        apb_req       = '0;
        reset         = 1'b1;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        check_reset_state();
        check_register_readback();
        check_directed_products();
        check_random_products();
        check_busy_and_refusal();
        check_unmapped_access();
        check_back_to_back();

        $display("errors: %0d check failures, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
toom3_pkg.sv
apb_regs.sv
toom3_sequencer.sv
clmul_seq.sv
exact_div.sv
toom3_top.sv
tb_toom3.sv
